// File: rtl/gtePkg.sv
/*
 * Geometry coprocessor register file definitions
 * Widths, register addresses and shared value types
 */
package gtePkg;

	// ----------------------------
	// Value types
	// ----------------------------
	typedef logic [5:0]  regId_t;	// Bit 5 selects control bank
	typedef logic [31:0] word_t;	// CPU word, MAC, RES1, LZCS
	typedef logic [15:0] half_t;	// Signed 16-bit register value
	typedef logic [7:0]  chan_t;	// Colour channel or code byte
	typedef logic [18:0] flags_t;	// Sticky flags, FLAG bits 30..12
	typedef logic [4:0]  rgb5_t;	// Saturated colour component
	typedef logic [5:0]  leadCnt_t;	// Leading count 1..32

	// ----------------------------
	// Data register map
	// ----------------------------
	// Input vectors
	localparam regId_t DR_VXY0 = 6'd0;
	localparam regId_t DR_VZ0  = 6'd1;
	localparam regId_t DR_VXY1 = 6'd2;
	localparam regId_t DR_VZ1  = 6'd3;
	localparam regId_t DR_VXY2 = 6'd4;
	localparam regId_t DR_VZ2  = 6'd5;
	localparam regId_t DR_RGBC = 6'd6;
	localparam regId_t DR_OTZ  = 6'd7;
	// Intermediate results
	localparam regId_t DR_IR0  = 6'd8;
	localparam regId_t DR_IR1  = 6'd9;
	localparam regId_t DR_IR2  = 6'd10;
	localparam regId_t DR_IR3  = 6'd11;
	// Screen FIFOs
	localparam regId_t DR_SXY0 = 6'd12;
	localparam regId_t DR_SXY1 = 6'd13;
	localparam regId_t DR_SXY2 = 6'd14;
	localparam regId_t DR_SXYP = 6'd15;	// Push address
	localparam regId_t DR_SZ0  = 6'd16;
	localparam regId_t DR_SZ1  = 6'd17;
	localparam regId_t DR_SZ2  = 6'd18;
	localparam regId_t DR_SZP  = 6'd19;	// Push address
	// Colour FIFO
	localparam regId_t DR_RGB0 = 6'd20;
	localparam regId_t DR_RGB1 = 6'd21;
	localparam regId_t DR_RGB2 = 6'd22;
	localparam regId_t DR_RES1 = 6'd23;	// Prohibited slot, plain storage
	// Accumulators
	localparam regId_t DR_MAC0 = 6'd24;
	localparam regId_t DR_MAC1 = 6'd25;
	localparam regId_t DR_MAC2 = 6'd26;
	localparam regId_t DR_MAC3 = 6'd27;
	// Packed colour and leading count
	localparam regId_t DR_IRGB = 6'd28;
	localparam regId_t DR_ORGB = 6'd29;
	localparam regId_t DR_LZCS = 6'd30;
	localparam regId_t DR_LZCR = 6'd31;

	// Only control register kept
	localparam regId_t CR_FLAG = 6'd63;

	// ----------------------------
	// Field positions
	// ----------------------------
	localparam int FLAG_LSB   = 12;	// Flags start here in FLAG word
	localparam int IRGB_SHIFT = 7;	// 5-bit colour vs IR scale

endpackage

// File: rtl/leadCount.sv
/*
 * Leading sign-bit count of a 32-bit word, result 1..32
 */
`timescale 1ns/1ps

module leadCount (
	input  gtePkg::word_t    i_value,
	output gtePkg::leadCnt_t o_count
);
	import gtePkg::*;

	word_t diff;	// Set where bit differs from sign

	assign diff = i_value ^ {32{i_value[31]}};

	// Priority search, highest differing bit wins
	always_comb begin
		o_count = leadCnt_t'(32);	// No bit differs
		for (int b = 0; b < 31; b++)
			if (diff[b])
				o_count = leadCnt_t'(31 - b);
	end

endmodule

// File: rtl/screenFifo.sv
/*
 * Screen coordinate FIFOs SX, SY and SZ
 * Three entries each, CPU direct or push write, coprocessor push
 */
`timescale 1ns/1ps

module screenFifo (
	input  logic           i_clk,
	input  logic           i_arstN,
	input  gtePkg::regId_t i_regId,
	input  logic           i_wrReg,
	input  gtePkg::word_t  i_dataIn,
	input  logic           i_pushX,
	input  logic           i_pushY,
	input  logic           i_pushZ,
	input  gtePkg::half_t  i_gteVal16,
	output gtePkg::half_t  o_sx0, o_sx1, o_sx2,
	output gtePkg::half_t  o_sy0, o_sy1, o_sy2,
	output gtePkg::half_t  o_sz0, o_sz1, o_sz2
);
	import gtePkg::*;

	logic [2:0] wrSxy;		// Direct SXY0..2
	logic [2:0] wrSz;		// Direct SZ0..2
	logic       wrSxyp, wrSzp;
	logic [2:0] push;		// Per coordinate, X Y Z
	logic [2:0] shift;		// Push or CPU push address
	logic [2:0] wrDir [3];	// Direct write per coordinate and entry
	half_t      cpuVal [3];	// CPU slice per coordinate
	half_t      newVal [3];	// Value entering entry 2
	half_t      fifo [3][3];	// [coord][entry]

	// Address decode
	assign wrSxy  = {3{i_wrReg}} & {i_regId == DR_SXY2, i_regId == DR_SXY1, i_regId == DR_SXY0};
	assign wrSz   = {3{i_wrReg}} & {i_regId == DR_SZ2, i_regId == DR_SZ1, i_regId == DR_SZ0};
	assign wrSxyp = i_wrReg && (i_regId == DR_SXYP);
	assign wrSzp  = i_wrReg && (i_regId == DR_SZP);

	assign push   = {i_pushZ, i_pushY, i_pushX};
	assign shift  = push | {wrSzp, wrSxyp, wrSxyp};	// SXYP moves X and Y together

	assign wrDir[0]  = wrSxy;
	assign wrDir[1]  = wrSxy;
	assign wrDir[2]  = wrSz;
	assign cpuVal[0] = i_dataIn[15:0];
	assign cpuVal[1] = i_dataIn[31:16];	// Y lives in upper half
	assign cpuVal[2] = i_dataIn[15:0];

	// Coprocessor value beats CPU data
	always_comb begin
		for (int c = 0; c < 3; c++)
			newVal[c] = push[c] ? i_gteVal16 : cpuVal[c];
	end

	// ----------------------------
	// FIFO storage
	// ----------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			for (int c = 0; c < 3; c++)
				for (int e = 0; e < 3; e++)
					fifo[c][e] <= '0;
		end else begin
			for (int c = 0; c < 3; c++) begin
				if (shift[c]) begin
					fifo[c][0] <= fifo[c][1];	// Oldest drops out
					fifo[c][1] <= fifo[c][2];
					fifo[c][2] <= newVal[c];
				end else begin
					for (int e = 0; e < 3; e++)
						if (wrDir[c][e])
							fifo[c][e] <= cpuVal[c];
				end
			end
		end
	end

	assign o_sx0 = fifo[0][0];
	assign o_sx1 = fifo[0][1];
	assign o_sx2 = fifo[0][2];
	assign o_sy0 = fifo[1][0];
	assign o_sy1 = fifo[1][1];
	assign o_sy2 = fifo[1][2];
	assign o_sz0 = fifo[2][0];
	assign o_sz1 = fifo[2][1];
	assign o_sz2 = fifo[2][2];

endmodule

// File: rtl/colorFifo.sv
/*
 * Colour FIFO RGB0..RGB2 and RGBC code register
 * Per-channel push, code byte rides along with blue
 */
`timescale 1ns/1ps

module colorFifo (
	input  logic           i_clk,
	input  logic           i_arstN,
	input  gtePkg::regId_t i_regId,
	input  logic           i_wrReg,
	input  gtePkg::word_t  i_dataIn,
	input  logic           i_pushR,
	input  logic           i_pushG,
	input  logic           i_pushB,
	input  gtePkg::chan_t  i_gteVal8,
	output gtePkg::word_t  o_rgb0,
	output gtePkg::word_t  o_rgb1,
	output gtePkg::word_t  o_rgb2,
	output gtePkg::word_t  o_rgbc
);
	import gtePkg::*;

	logic [2:0] wrEnt;		// CPU write RGB0..2
	logic       wrRgbc;
	logic [3:0] lanePush;	// Lanes R G B code
	chan_t      ent [3][4];	// [entry][lane]
	word_t      rgbc;

	assign wrEnt    = {3{i_wrReg}} & {i_regId == DR_RGB2, i_regId == DR_RGB1, i_regId == DR_RGB0};
	assign wrRgbc   = i_wrReg && (i_regId == DR_RGBC);
	assign lanePush = {i_pushB, i_pushB, i_pushG, i_pushR};	// Code follows blue

	// ----------------------------
	// Entries and code register
	// ----------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			rgbc <= '0;
			for (int e = 0; e < 3; e++)
				for (int l = 0; l < 4; l++)
					ent[e][l] <= '0;
		end else begin
			if (wrRgbc)
				rgbc <= i_dataIn;
			for (int l = 0; l < 4; l++) begin
				if (lanePush[l]) begin
					ent[0][l] <= ent[1][l];
					ent[1][l] <= ent[2][l];
					// Code lane refills from RGBC
					ent[2][l] <= (l == 3) ? rgbc[31:24] : i_gteVal8;
				end else begin
					for (int e = 0; e < 3; e++)
						if (wrEnt[e])
							ent[e][l] <= i_dataIn[8*l +: 8];
				end
			end
		end
	end

	// Packed as code, B, G, R
	assign o_rgb0 = {ent[0][3], ent[0][2], ent[0][1], ent[0][0]};
	assign o_rgb1 = {ent[1][3], ent[1][2], ent[1][1], ent[1][0]};
	assign o_rgb2 = {ent[2][3], ent[2][2], ent[2][1], ent[2][0]};
	assign o_rgbc = rgbc;

endmodule

// File: rtl/gteDataRegs.sv
/*
 * General data registers and sticky FLAG register
 * Vectors, OTZ, IR with IRGB unpack, MAC, RES1, LZCS
 */
`timescale 1ns/1ps

module gteDataRegs (
	input  logic           i_clk,
	input  logic           i_arstN,
	input  gtePkg::regId_t i_regId,
	input  logic           i_wrReg,
	input  gtePkg::word_t  i_dataIn,
	input  logic [3:0]     i_wrIr,
	input  logic [3:0]     i_wrMac,
	input  gtePkg::half_t  i_gteVal16,
	input  gtePkg::word_t  i_gteVal32,
	input  gtePkg::flags_t i_flagsSet,
	output gtePkg::half_t  o_vx0, o_vy0, o_vz0,
	output gtePkg::half_t  o_vx1, o_vy1, o_vz1,
	output gtePkg::half_t  o_vx2, o_vy2, o_vz2,
	output gtePkg::half_t  o_otz,
	output gtePkg::half_t  o_ir0, o_ir1, o_ir2, o_ir3,
	output gtePkg::word_t  o_mac0, o_mac1, o_mac2, o_mac3,
	output gtePkg::word_t  o_res1,
	output gtePkg::word_t  o_lzcs,
	output gtePkg::flags_t o_flags
);
	import gtePkg::*;

	logic [2:0] cpuVxy, cpuVz;
	logic [3:0] cpuIr, cpuMac;
	logic       wrIrgb;
	half_t      irCpuVal [4];
	half_t      vx [3], vy [3], vz [3];
	half_t      otz;
	half_t      ir [4];
	word_t      mac [4];
	word_t      res1, lzcs;
	flags_t     flags;

	// 5-bit colour component back to IR scale
	function automatic half_t irgbField(input rgb5_t c);
		return half_t'(c) << IRGB_SHIFT;
	endfunction

	// ----------------------------
	// Write decode
	// ----------------------------
	assign cpuVxy = {3{i_wrReg}} & {i_regId == DR_VXY2, i_regId == DR_VXY1, i_regId == DR_VXY0};
	assign cpuVz  = {3{i_wrReg}} & {i_regId == DR_VZ2, i_regId == DR_VZ1, i_regId == DR_VZ0};
	assign cpuMac = {4{i_wrReg}} & {i_regId == DR_MAC3, i_regId == DR_MAC2,
	                                i_regId == DR_MAC1, i_regId == DR_MAC0};
	assign wrIrgb = i_wrReg && (i_regId == DR_IRGB);
	// IRGB write hits IR1..IR3 at once
	assign cpuIr[0] = i_wrReg && (i_regId == DR_IR0);
	assign cpuIr[1] = (i_wrReg && (i_regId == DR_IR1)) || wrIrgb;
	assign cpuIr[2] = (i_wrReg && (i_regId == DR_IR2)) || wrIrgb;
	assign cpuIr[3] = (i_wrReg && (i_regId == DR_IR3)) || wrIrgb;

	assign irCpuVal[0] = i_dataIn[15:0];
	assign irCpuVal[1] = wrIrgb ? irgbField(i_dataIn[4:0])   : i_dataIn[15:0];	// R
	assign irCpuVal[2] = wrIrgb ? irgbField(i_dataIn[9:5])   : i_dataIn[15:0];	// G
	assign irCpuVal[3] = wrIrgb ? irgbField(i_dataIn[14:10]) : i_dataIn[15:0];	// B

	// ----------------------------
	// Storage
	// ----------------------------
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			for (int n = 0; n < 3; n++) begin
				vx[n] <= '0;
				vy[n] <= '0;
				vz[n] <= '0;
			end
			for (int n = 0; n < 4; n++) begin
				ir[n]  <= '0;
				mac[n] <= '0;
			end
			otz   <= '0;
			res1  <= '0;
			lzcs  <= '0;
			flags <= '0;
		end else begin
			for (int n = 0; n < 3; n++) begin	// Vectors, CPU only
				if (cpuVxy[n]) begin
					vx[n] <= i_dataIn[15:0];
					vy[n] <= i_dataIn[31:16];
				end
				if (cpuVz[n])
					vz[n] <= i_dataIn[15:0];
			end
			for (int n = 0; n < 4; n++) begin
				if (i_wrIr[n])		// Coprocessor wins
					ir[n] <= i_gteVal16;
				else if (cpuIr[n])
					ir[n] <= irCpuVal[n];
				if (i_wrMac[n])
					mac[n] <= i_gteVal32;
				else if (cpuMac[n])
					mac[n] <= i_dataIn;
			end
			if (i_wrReg && (i_regId == DR_OTZ))  otz  <= i_dataIn[15:0];
			if (i_wrReg && (i_regId == DR_RES1)) res1 <= i_dataIn;
			if (i_wrReg && (i_regId == DR_LZCS)) lzcs <= i_dataIn;
			// Sticky unless CPU reloads
			if (i_wrReg && (i_regId == CR_FLAG))
				flags <= i_dataIn[30:FLAG_LSB];
			else
				flags <= flags | i_flagsSet;
		end
	end

	assign o_vx0 = vx[0];
	assign o_vy0 = vy[0];
	assign o_vz0 = vz[0];
	assign o_vx1 = vx[1];
	assign o_vy1 = vy[1];
	assign o_vz1 = vz[1];
	assign o_vx2 = vx[2];
	assign o_vy2 = vy[2];
	assign o_vz2 = vz[2];
	assign o_otz = otz;
	assign o_ir0 = ir[0];
	assign o_ir1 = ir[1];
	assign o_ir2 = ir[2];
	assign o_ir3 = ir[3];
	assign o_mac0  = mac[0];
	assign o_mac1  = mac[1];
	assign o_mac2  = mac[2];
	assign o_mac3  = mac[3];
	assign o_res1  = res1;
	assign o_lzcs  = lzcs;
	assign o_flags = flags;

endmodule

// File: rtl/gteReadMux.sv
/*
 * CPU readback mux for the coprocessor registers
 * Extension rules, FLAG summary bit and IRGB/ORGB saturation
 */
`timescale 1ns/1ps

module gteReadMux (
	input  gtePkg::regId_t   i_regId,
	input  gtePkg::half_t    i_sx0, i_sx1, i_sx2,
	input  gtePkg::half_t    i_sy0, i_sy1, i_sy2,
	input  gtePkg::half_t    i_sz0, i_sz1, i_sz2,
	input  gtePkg::word_t    i_rgb0, i_rgb1, i_rgb2, i_rgbc,
	input  gtePkg::half_t    i_vx0, i_vy0, i_vz0,
	input  gtePkg::half_t    i_vx1, i_vy1, i_vz1,
	input  gtePkg::half_t    i_vx2, i_vy2, i_vz2,
	input  gtePkg::half_t    i_otz,
	input  gtePkg::half_t    i_ir0, i_ir1, i_ir2, i_ir3,
	input  gtePkg::word_t    i_mac0, i_mac1, i_mac2, i_mac3,
	input  gtePkg::word_t    i_res1,
	input  gtePkg::word_t    i_lzcs,
	input  gtePkg::flags_t   i_flags,
	input  gtePkg::leadCnt_t i_leadCnt,
	output gtePkg::word_t    o_dataOut
);
	import gtePkg::*;

	rgb5_t r5, g5, b5;
	word_t rgbWord;		// Shared by IRGB and ORGB
	word_t flagWord;
	logic  flagSum;

	function automatic word_t sext(input half_t v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic word_t zext(input half_t v);
		return {16'd0, v};
	endfunction

	// IR down to 5 bits, clamp 0..31
	function automatic rgb5_t sat5(input half_t v);
		half_t scaled;
		scaled = half_t'($signed(v) >>> IRGB_SHIFT);
		if (scaled[15])
			return '0;				// Negative
		else if (scaled > half_t'(31))
			return rgb5_t'(31);
		else
			return scaled[4:0];
	endfunction

	// ----------------------------
	// Derived read values
	// ----------------------------
	assign r5 = sat5(i_ir1);
	assign g5 = sat5(i_ir2);
	assign b5 = sat5(i_ir3);
	assign rgbWord = {17'd0, b5, g5, r5};

	// FLAG bits 30..23 and 18..13 only
	assign flagSum  = (|i_flags[30-FLAG_LSB:23-FLAG_LSB]) | (|i_flags[18-FLAG_LSB:13-FLAG_LSB]);
	assign flagWord = {flagSum, i_flags, {FLAG_LSB{1'b0}}};

	// ----------------------------
	// Address decode
	// ----------------------------
	always_comb begin
		case (i_regId)
			DR_VXY0: o_dataOut = {i_vy0, i_vx0};
			DR_VZ0:  o_dataOut = sext(i_vz0);
			DR_VXY1: o_dataOut = {i_vy1, i_vx1};
			DR_VZ1:  o_dataOut = sext(i_vz1);
			DR_VXY2: o_dataOut = {i_vy2, i_vx2};
			DR_VZ2:  o_dataOut = sext(i_vz2);
			DR_RGBC: o_dataOut = i_rgbc;
			DR_OTZ:  o_dataOut = zext(i_otz);	// Unsigned
			DR_IR0:  o_dataOut = sext(i_ir0);
			DR_IR1:  o_dataOut = sext(i_ir1);
			DR_IR2:  o_dataOut = sext(i_ir2);
			DR_IR3:  o_dataOut = sext(i_ir3);
			DR_SXY0: o_dataOut = {i_sy0, i_sx0};
			DR_SXY1: o_dataOut = {i_sy1, i_sx1};
			DR_SXY2,
			DR_SXYP: o_dataOut = {i_sy2, i_sx2};	// Push address mirrors entry 2
			DR_SZ0:  o_dataOut = zext(i_sz0);
			DR_SZ1:  o_dataOut = zext(i_sz1);
			DR_SZ2,
			DR_SZP:  o_dataOut = zext(i_sz2);
			DR_RGB0: o_dataOut = i_rgb0;
			DR_RGB1: o_dataOut = i_rgb1;
			DR_RGB2: o_dataOut = i_rgb2;
			DR_RES1: o_dataOut = i_res1;
			DR_MAC0: o_dataOut = i_mac0;
			DR_MAC1: o_dataOut = i_mac1;
			DR_MAC2: o_dataOut = i_mac2;
			DR_MAC3: o_dataOut = i_mac3;
			DR_IRGB,
			DR_ORGB: o_dataOut = rgbWord;
			DR_LZCS: o_dataOut = i_lzcs;
			DR_LZCR: o_dataOut = word_t'(i_leadCnt);
			CR_FLAG: o_dataOut = flagWord;
			default: o_dataOut = '0;	// Other control addresses
		endcase
	end

endmodule

// File: rtl/gteRegTop.sv
/*
 * Coprocessor register file top
 * Screen and colour FIFOs, data registers, leading count, readback
 */
`timescale 1ns/1ps

module gteRegTop (
	input  logic           i_clk,
	input  logic           i_arstN,
	input  gtePkg::regId_t i_regId,
	input  logic           i_wrReg,
	input  gtePkg::word_t  i_dataIn,
	input  logic           i_pushX,
	input  logic           i_pushY,
	input  logic           i_pushZ,
	input  logic           i_pushR,
	input  logic           i_pushG,
	input  logic           i_pushB,
	input  logic [3:0]     i_wrIr,
	input  logic [3:0]     i_wrMac,
	input  gtePkg::chan_t  i_gteVal8,
	input  gtePkg::half_t  i_gteVal16,
	input  gtePkg::word_t  i_gteVal32,
	input  gtePkg::flags_t i_flagsSet,
	output gtePkg::word_t  o_dataOut
);
	import gtePkg::*;

	// ----------------------------
	// Bank outputs
	// ----------------------------
	half_t    sx0, sx1, sx2, sy0, sy1, sy2, sz0, sz1, sz2;
	word_t    rgb0, rgb1, rgb2, rgbc;
	half_t    vx0, vy0, vz0, vx1, vy1, vz1, vx2, vy2, vz2;
	half_t    otz, ir0, ir1, ir2, ir3;
	word_t    mac0, mac1, mac2, mac3, res1, lzcs;
	flags_t   flags;
	leadCnt_t leadCnt;

	screenFifo u_screen (
		.i_clk, .i_arstN, .i_regId, .i_wrReg, .i_dataIn,
		.i_pushX, .i_pushY, .i_pushZ, .i_gteVal16,
		.o_sx0(sx0), .o_sx1(sx1), .o_sx2(sx2),
		.o_sy0(sy0), .o_sy1(sy1), .o_sy2(sy2),
		.o_sz0(sz0), .o_sz1(sz1), .o_sz2(sz2)
	);

	colorFifo u_color (
		.i_clk, .i_arstN, .i_regId, .i_wrReg, .i_dataIn,
		.i_pushR, .i_pushG, .i_pushB, .i_gteVal8,
		.o_rgb0(rgb0), .o_rgb1(rgb1), .o_rgb2(rgb2), .o_rgbc(rgbc)
	);

	gteDataRegs u_data (
		.i_clk, .i_arstN, .i_regId, .i_wrReg, .i_dataIn,
		.i_wrIr, .i_wrMac, .i_gteVal16, .i_gteVal32, .i_flagsSet,
		.o_vx0(vx0), .o_vy0(vy0), .o_vz0(vz0),
		.o_vx1(vx1), .o_vy1(vy1), .o_vz1(vz1),
		.o_vx2(vx2), .o_vy2(vy2), .o_vz2(vz2),
		.o_otz(otz), .o_ir0(ir0), .o_ir1(ir1), .o_ir2(ir2), .o_ir3(ir3),
		.o_mac0(mac0), .o_mac1(mac1), .o_mac2(mac2), .o_mac3(mac3),
		.o_res1(res1), .o_lzcs(lzcs), .o_flags(flags)
	);

	// LZCR source
	leadCount u_lead (
		.i_value(lzcs),
		.o_count(leadCnt)
	);

	gteReadMux u_read (
		.i_regId,
		.i_sx0(sx0), .i_sx1(sx1), .i_sx2(sx2),
		.i_sy0(sy0), .i_sy1(sy1), .i_sy2(sy2),
		.i_sz0(sz0), .i_sz1(sz1), .i_sz2(sz2),
		.i_rgb0(rgb0), .i_rgb1(rgb1), .i_rgb2(rgb2), .i_rgbc(rgbc),
		.i_vx0(vx0), .i_vy0(vy0), .i_vz0(vz0),
		.i_vx1(vx1), .i_vy1(vy1), .i_vz1(vz1),
		.i_vx2(vx2), .i_vy2(vy2), .i_vz2(vz2),
		.i_otz(otz), .i_ir0(ir0), .i_ir1(ir1), .i_ir2(ir2), .i_ir3(ir3),
		.i_mac0(mac0), .i_mac1(mac1), .i_mac2(mac2), .i_mac3(mac3),
		.i_res1(res1), .i_lzcs(lzcs), .i_flags(flags),
		.i_leadCnt(leadCnt),
		.o_dataOut
	);

endmodule

// File: tb/tbClockGen.sv
/*
 * Testbench clock and reset source
 * 100 ns clock, reset held low for 3 cycles
 */
`timescale 1ns/1ps

module tbClockGen (
	output logic o_clk,
	output logic o_arstN
);
	initial o_clk = 1'b0;
	always #50 o_clk = ~o_clk;	// 100 ns period

	initial begin
		o_arstN = 1'b0;
		repeat (3) @(posedge o_clk);
		@(negedge o_clk);		// Release away from active edge
		o_arstN = 1'b1;
	end

endmodule

// File: tb/gteRegs_assertions.sv
/*
 * Concurrent checks on the register file readback
 * Bound into the top level
 */
`timescale 1ns/1ps

module gteRegs_assertions (
	input logic           i_clk,
	input logic           i_arstN,
	input gtePkg::regId_t i_regId,
	input gtePkg::word_t  i_dataOut
);
	import gtePkg::*;

	// ----------------------------
	// Readback properties
	// ----------------------------
	// Readback fully defined out of reset
	noUnknownRead: assert property (@(posedge i_clk) disable iff (!i_arstN)
		!$isunknown(i_dataOut))
		else $error("Readback has unknown bits");

	// Leading count 1..32
	lzcrRange: assert property (@(posedge i_clk) disable iff (!i_arstN)
		(i_regId == DR_LZCR) |-> (i_dataOut >= 32'd1 && i_dataOut <= 32'd32))
		else $error("LZCR read out of range");

	// Bit 31 summarises 30..23 and 18..13
	flagSummary: assert property (@(posedge i_clk) disable iff (!i_arstN)
		(i_regId == CR_FLAG) |-> (i_dataOut[31] == ((|i_dataOut[30:23]) | (|i_dataOut[18:13]))))
		else $error("FLAG summary bit mismatch");

endmodule

bind gteRegTop gteRegs_assertions u_assert (
	.i_clk(i_clk),
	.i_arstN(i_arstN),
	.i_regId(i_regId),
	.i_dataOut(o_dataOut)
);

// File: tb/tbGteRegs.sv
/*
 * Directed testbench for the coprocessor register file
 * FIFOs, extension rules, IRGB, leading count and FLAG
 */
`timescale 1ns/1ps

module tbGteRegs;
	import gtePkg::*;

	localparam int TIMEOUT_CYCLES = 2000;	// About 4x the test length

	logic     clk, arstN;
	regId_t   regId;
	logic     wrReg;
	word_t    dataIn;
	logic     pushX, pushY, pushZ, pushR, pushG, pushB;
	logic [3:0] wrIr, wrMac;
	chan_t    gteVal8;
	half_t    gteVal16;
	word_t    gteVal32;
	flags_t   flagsSet;
	word_t    dataOut;
	int unsigned cycleCnt = 0;

	// Expected state models
	half_t    scr [3][3];	// [coord X Y Z][entry]
	chan_t    col [3][4];	// [entry][lane R G B code]
	word_t    rgbcM;
	flags_t   flagsM;

	tbClockGen u_clkGen (.o_clk(clk), .o_arstN(arstN));

	gteRegTop u_dut (
		.i_clk(clk), .i_arstN(arstN), .i_regId(regId), .i_wrReg(wrReg), .i_dataIn(dataIn),
		.i_pushX(pushX), .i_pushY(pushY), .i_pushZ(pushZ),
		.i_pushR(pushR), .i_pushG(pushG), .i_pushB(pushB),
		.i_wrIr(wrIr), .i_wrMac(wrMac), .i_gteVal8(gteVal8), .i_gteVal16(gteVal16),
		.i_gteVal32(gteVal32), .i_flagsSet(flagsSet), .o_dataOut(dataOut)
	);

	// ----------------------------
	// Run control
	// ----------------------------
	task automatic abortRun();
		$display("Test failures found");
		$fatal(1, "Stopped at first failing check");
	endtask

	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", cycleCnt);
			abortRun();
		end
	end

	// ----------------------------
	// Drive and compare helpers
	// ----------------------------
	// Each helper starts on a falling edge and returns on a later one
	task automatic idleInputs();
		wrReg    = 1'b0;
		{pushX, pushY, pushZ, pushR, pushG, pushB} = '0;
		wrIr     = '0;
		wrMac    = '0;
		flagsSet = '0;
	endtask

	task automatic beginWrite(input regId_t id, input word_t d);
		regId  = id;
		dataIn = d;
		wrReg  = 1'b1;
	endtask

	task automatic endCycle();
		@(negedge clk);	// Strobes seen by one rising edge
		idleInputs();
	endtask

	task automatic writeReg(input regId_t id, input word_t d);
		beginWrite(id, d);
		endCycle();
	endtask

	task automatic readReg(input regId_t id, output word_t d);
		regId = id;
		#10 d = dataOut;	// Settled early in low phase
		@(negedge clk);
	endtask

	task automatic checkWord(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("** Error: %s expected 0x%08h got 0x%08h", name, exp, act);
			abortRun();
		end
	endtask

	task automatic checkHalf(input string name, input half_t exp, input half_t act);
		if (act !== exp) begin
			$display("** Error: %s expected 0x%04h got 0x%04h", name, exp, act);
			abortRun();
		end
	endtask

	task automatic readCheck(input regId_t id, input word_t exp, input string name);
		word_t d;
		readReg(id, d);
		checkWord(name, exp, d);
	endtask

	// ----------------------------
	// Reference rules
	// ----------------------------
	// Leading bits equal to bit 31
	function automatic int leadRef(input word_t v);
		int n;
		n = 1;
		while (n < 32 && v[31 - n] == v[31])
			n++;
		return n;
	endfunction

	// IR / 128 clamped to 0..31
	function automatic rgb5_t sat5Ref(input half_t ir);
		int v;
		v = int'($signed(ir)) >>> IRGB_SHIFT;
		if (v < 0)
			return '0;
		if (v > 31)
			return 5'd31;
		return rgb5_t'(v);
	endfunction

	function automatic word_t flagExp(input flags_t f);
		word_t w;
		w = {1'b0, f, 12'h000};
		w[31] = (|w[30:23]) | (|w[18:13]);	// Summary bit
		return w;
	endfunction

	task automatic shiftScr(input int c, input half_t v);
		scr[c][0] = scr[c][1];
		scr[c][1] = scr[c][2];
		scr[c][2] = v;
	endtask

	task automatic shiftCol(input int l, input chan_t v);
		col[0][l] = col[1][l];
		col[1][l] = col[2][l];
		col[2][l] = v;
	endtask

	task automatic checkScreen();
		word_t d;
		for (int e = 0; e < 3; e++) begin
			readReg(regId_t'(DR_SXY0 + e), d);
			checkHalf($sformatf("SX%0d", e), scr[0][e], d[15:0]);
			checkHalf($sformatf("SY%0d", e), scr[1][e], d[31:16]);
			readCheck(regId_t'(DR_SZ0 + e), {16'h0, scr[2][e]}, $sformatf("SZ%0d", e));
		end
		readReg(DR_SXYP, d);	// Mirrors entry 2
		checkHalf("SXYP x", scr[0][2], d[15:0]);
		checkHalf("SXYP y", scr[1][2], d[31:16]);
		readCheck(DR_SZP, {16'h0, scr[2][2]}, "SZP");
	endtask

	task automatic checkColor();
		for (int e = 0; e < 3; e++)
			readCheck(regId_t'(DR_RGB0 + e), {col[e][3], col[e][2], col[e][1], col[e][0]},
				$sformatf("RGB%0d", e));
		readCheck(DR_RGBC, rgbcM, "RGBC");
	endtask

	// ----------------------------
	// Directed tests
	// ----------------------------
	task automatic testResetAndBasic();
		for (int a = 0; a < 64; a++)	// LZCS zero gives count 32
			readCheck(regId_t'(a), (a == DR_LZCR) ? word_t'(32) : word_t'(0),
				$sformatf("reset read %0d", a));
		writeReg(DR_VXY0, 32'h8001_1234);
		readCheck(DR_VXY0, 32'h8001_1234, "VXY0");
		writeReg(DR_VZ0, 32'h1234_F00D);
		readCheck(DR_VZ0, 32'hFFFF_F00D, "VZ0");		// Sign extended
		writeReg(DR_OTZ, 32'hFFFF_8123);
		readCheck(DR_OTZ, 32'h0000_8123, "OTZ");		// Zero extended
		writeReg(DR_IR0, 32'h0000_C000);
		readCheck(DR_IR0, 32'hFFFF_C000, "IR0");
		writeReg(DR_MAC2, 32'hDEAD_BEEF);
		readCheck(DR_MAC2, 32'hDEAD_BEEF, "MAC2");
		writeReg(regId_t'(40), 32'hFFFF_FFFF);	// Dropped control register
		readCheck(regId_t'(40), '0, "control 40");
	endtask

	task automatic testScreenFifo();
		word_t d;
		for (int e = 0; e < 3; e++) begin
			d = $urandom();
			writeReg(regId_t'(DR_SXY0 + e), d);
			scr[0][e] = d[15:0];
			scr[1][e] = d[31:16];
			d = $urandom();
			writeReg(regId_t'(DR_SZ0 + e), d);
			scr[2][e] = d[15:0];
		end
		checkScreen();
		d = $urandom();
		writeReg(DR_SXYP, d);		// X and Y shift together
		shiftScr(0, d[15:0]);
		shiftScr(1, d[31:16]);
		d = $urandom();
		writeReg(DR_SZP, d);
		shiftScr(2, d[15:0]);
		checkScreen();
		pushX    = 1'b1;
		gteVal16 = 16'h1111;
		endCycle();
		shiftScr(0, 16'h1111);
		pushY    = 1'b1;
		pushZ    = 1'b1;
		gteVal16 = 16'h2222;
		endCycle();
		shiftScr(1, 16'h2222);
		shiftScr(2, 16'h2222);
		checkScreen();
		// Push and direct SXY2 write in one cycle
		beginWrite(DR_SXY2, 32'h0AAA_0BBB);
		pushX    = 1'b1;
		gteVal16 = 16'h4444;
		endCycle();
		shiftScr(0, 16'h4444);		// Coprocessor wins on X
		scr[1][2] = 16'h0AAA;		// Y takes CPU data
		beginWrite(DR_SZ2, 32'h0000_0CCC);
		pushZ    = 1'b1;
		gteVal16 = 16'h5555;
		endCycle();
		shiftScr(2, 16'h5555);
		checkScreen();
	endtask

	task automatic testColorFifo();
		word_t d;
		rgbcM = 32'hC0_33_22_11;
		writeReg(DR_RGBC, rgbcM);
		for (int e = 0; e < 3; e++) begin
			d = $urandom();
			writeReg(regId_t'(DR_RGB0 + e), d);
			for (int l = 0; l < 4; l++)
				col[e][l] = d[8*l +: 8];
		end
		checkColor();
		pushR   = 1'b1;
		gteVal8 = 8'h5A;
		endCycle();
		shiftCol(0, 8'h5A);		// Red lane only
		checkColor();
		pushB   = 1'b1;
		gteVal8 = 8'hA5;
		endCycle();
		shiftCol(2, 8'hA5);
		shiftCol(3, rgbcM[31:24]);	// Code refilled from RGBC
		checkColor();
	endtask

	task automatic testIrgb();
		word_t d;
		word_t irgbExp;
		half_t ir1, ir2, ir3;
		d = {17'h0, 5'd31, 5'd17, 5'd3};
		writeReg(DR_IRGB, d);
		readCheck(DR_IR1, 32'h0000_0180, "IR1 from IRGB");	// 3 x 128
		readCheck(DR_IR2, 32'h0000_0880, "IR2 from IRGB");	// 17 x 128
		readCheck(DR_IR3, 32'h0000_0F80, "IR3 from IRGB");	// 31 x 128
		readCheck(DR_IRGB, d, "IRGB round trip");
		ir1 = 16'hFF00;		// Negative
		ir2 = 16'h0A40;		// Mid range
		ir3 = 16'h7FFF;		// Above 31 after scaling
		writeReg(DR_IR1, {16'h5555, ir1});
		writeReg(DR_IR2, {16'h5555, ir2});
		writeReg(DR_IR3, {16'h5555, ir3});
		readCheck(DR_IR1, {{16{ir1[15]}}, ir1}, "IR1");
		irgbExp = {17'h0, sat5Ref(ir3), sat5Ref(ir2), sat5Ref(ir1)};
		readCheck(DR_IRGB, irgbExp, "IRGB clamp");
		readCheck(DR_ORGB, irgbExp, "ORGB clamp");
		// wrIr against CPU write
		beginWrite(DR_IR2, 32'h0000_1234);
		wrIr     = 4'b0100;
		gteVal16 = 16'h0567;
		endCycle();
		readReg(DR_IR2, d);
		checkHalf("IR2 collision", 16'h0567, d[15:0]);
	endtask

	task automatic testLeadCount();
		word_t pats [$];
		pats.push_back(32'h0000_0000);
		pats.push_back(32'hFFFF_FFFF);
		for (int b = 0; b < 32; b++)
			pats.push_back(word_t'(1) << b);
		for (int n = 0; n < 20; n++)
			pats.push_back($urandom());
		foreach (pats[i]) begin
			writeReg(DR_LZCS, pats[i]);
			readCheck(DR_LZCS, pats[i], "LZCS");
			readCheck(DR_LZCR, word_t'(leadRef(pats[i])), $sformatf("LZCR of %08h", pats[i]));
		end
	endtask

	task automatic testFlags();
		word_t d;
		flagsM = '0;
		flagsSet = 19'h00001;		// Bit 12 lies outside summary
		endCycle();
		flagsM |= 19'h00001;
		readCheck(CR_FLAG, flagExp(flagsM), "FLAG bit 12");
		flagsSet = 19'h40000;		// Bit 30
		endCycle();
		flagsM |= 19'h40000;
		readCheck(CR_FLAG, flagExp(flagsM), "FLAG sticky");
		// CPU load beats accumulate
		d = 32'h8004_0FFF;
		beginWrite(CR_FLAG, d);
		flagsSet = 19'h7FFFF;
		endCycle();
		flagsM = d[30:12];
		readCheck(CR_FLAG, flagExp(flagsM), "FLAG load bit 18");
		d = 32'h0008_0000;		// Bit 19 not in summary
		writeReg(CR_FLAG, d);
		flagsM = d[30:12];
		readCheck(CR_FLAG, flagExp(flagsM), "FLAG load bit 19");
		// MAC strobes with MAC3 also hit by CPU
		beginWrite(DR_MAC3, 32'h1111_1111);
		wrMac    = 4'b1001;
		gteVal32 = 32'h1357_9BDF;
		endCycle();
		readCheck(DR_MAC0, 32'h1357_9BDF, "MAC0");
		readCheck(DR_MAC1, 32'h0000_0000, "MAC1");
		readCheck(DR_MAC2, 32'hDEAD_BEEF, "MAC2 kept");
		readCheck(DR_MAC3, 32'h1357_9BDF, "MAC3 collision");
	endtask

	// ----------------------------
	// Main sequence
	// ----------------------------
	initial begin
		void'($urandom(44732));
		regId    = '0;
		dataIn   = '0;
		gteVal8  = '0;
		gteVal16 = '0;
		gteVal32 = '0;
		idleInputs();
		@(posedge arstN);
		@(negedge clk);
		testResetAndBasic();
		testScreenFifo();
		testColorFifo();
		testIrgb();
		testLeadCount();
		testFlags();
		$display("All tests passed!");
		$finish;
	end

endmodule

// File: files.f
rtl/gtePkg.sv
rtl/leadCount.sv
rtl/screenFifo.sv
rtl/colorFifo.sv
rtl/gteDataRegs.sv
rtl/gteReadMux.sv
rtl/gteRegTop.sv
tb/tbClockGen.sv
tb/gteRegs_assertions.sv
tb/tbGteRegs.sv

// File: Makefile
# Verilator flow for the coprocessor register file testbench

VERILATOR ?= verilator
TOP       ?= tbGteRegs
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A missing pass line also counts as failure (assertion stop, crash)
run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation OK"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
